// File: build.f
hw/hsid_pkg.sv
hw/hsid_fifo.sv
hw/hsid_main_fsm.sv
hw/hsid_mse.sv
hw/hsid_min_search.sv
hw/hsid_top.sv
verification/hsid_clk_gen.sv
verification/hsid_tb.sv

// File: hw/hsid_fifo.sv
`timescale 1ns/1ps

module hsid_fifo #(
  parameter type payload_t = logic,  // Stored word type
  parameter int  DEPTH     = 4       // Number of entries
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     wr_en,    // Push request
  input  payload_t wr_data,  // Word to push
  input  logic     rd_en,    // Pop request
  output payload_t rd_data,  // Popped word, one cycle after rd_en
  output logic     full,     // No free entry
  output logic     empty     // No stored entry
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  payload_t               mem [DEPTH];  // Storage array
  logic [PTR_WIDTH-1:0]   wr_ptr;       // Next slot to write
  logic [PTR_WIDTH-1:0]   rd_ptr;       // Next slot to read
  logic [CNT_WIDTH-1:0]   count;        // Occupancy
  logic                   do_wr;
  logic                   do_rd;

  assign full  = (count == CNT_WIDTH'(DEPTH));
  assign empty = (count == '0);

  assign do_rd = rd_en && !empty;            // Ignore pop when empty
  assign do_wr = wr_en && (!full || do_rd);  // Full is fine if a pop frees a slot

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;  // Wrap
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
    if (do_rd) begin
      rd_data <= mem[rd_ptr];  // Valid the cycle after the pop
    end
  end

endmodule

// File: hw/hsid_main_fsm.sv
`timescale 1ns/1ps

module hsid_main_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  hsid_pkg::lib_size_t          hsi_library_size,      // Vectors in this run
  input  logic                         fifo_measure_full,     // Pixel fully loaded
  input  logic                         fifo_measure_empty,
  input  logic                         fifo_ref_empty,
  input  logic                         fifo_ref_full,         // Back-pressure source
  input  logic                         msi_valid,             // Final MSE out
  input  logic                         msi_comparison_valid,  // Final compare out
  input  logic                         start,
  output hsid_pkg::hsid_main_state_t   state,
  output hsid_pkg::lib_index_t         vctr_count,            // Vector on buffer outputs
  output logic                         element_start,         // First word of a vector
  output logic                         element_last,          // Last word of a vector
  output logic                         element_valid,         // Buffer outputs valid
  output logic                         vctr_last,             // Current vector is the last
  output logic                         fifo_both_read_en,     // Joint pop
  output logic                         done,
  output logic                         idle,
  output logic                         ready
);

  hsid_pkg::hsid_main_state_t          current_state;
  hsid_pkg::hsid_main_state_t          next_state;
  logic [hsid_pkg::ELEMENTS_ADDR-1:0]  element_count;  // Word position on the read side
  logic                                word_first;
  logic                                word_last;

  assign state = current_state;

  // Pop both buffers together whenever both hold a word
  assign fifo_both_read_en = (current_state == hsid_pkg::COMPUTE_MSE) &&
                             !fifo_ref_empty && !fifo_measure_empty;

  assign word_first = (element_count == '0);
  assign word_last  = (element_count == hsid_pkg::ELEMENTS_ADDR'(hsid_pkg::ELEMENTS - 1));

  // Aligned with the element strobes, not with the pop
  assign vctr_last = ({1'b0, vctr_count} == hsi_library_size - 1'b1);

  // State, counters and registered strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      current_state <= hsid_pkg::IDLE;
      element_count <= '0;
      vctr_count    <= '0;
      element_start <= 1'b0;
      element_last  <= 1'b0;
      element_valid <= 1'b0;
    end else begin
      current_state <= next_state;
      element_valid <= fifo_both_read_en;               // Data lands next cycle
      element_start <= fifo_both_read_en && word_first;
      element_last  <= fifo_both_read_en && word_last;
      if (current_state == hsid_pkg::IDLE) begin
        element_count <= '0;  // Fresh run
        vctr_count    <= '0;
      end else begin
        if (fifo_both_read_en) begin
          element_count <= element_count + 1'b1;  // Wraps per vector
        end
        if (element_valid && element_last) begin
          vctr_count <= vctr_count + 1'b1;  // Next vector reaches the outputs
        end
      end
    end
  end

  // Next state and handshake levels
  always_comb begin
    next_state = current_state;
    idle       = 1'b0;
    ready      = 1'b0;
    done       = 1'b0;
    case (current_state)
      hsid_pkg::IDLE: begin
        idle = 1'b1;
        if (start) begin
          next_state = hsid_pkg::READ_MEASURE;
        end
      end
      hsid_pkg::READ_MEASURE: begin
        ready = 1'b1;  // Host loads the pixel
        if (fifo_measure_full) begin
          next_state = hsid_pkg::COMPUTE_MSE;
        end
      end
      hsid_pkg::COMPUTE_MSE: begin
        ready = !fifo_ref_full;  // Throttle on the reference buffer
        // Last word of last vector is on the buffer outputs
        if (element_valid && element_last && vctr_last) begin
          next_state = hsid_pkg::WAIT_MSE;
        end
      end
      hsid_pkg::WAIT_MSE: begin
        if (msi_valid) begin
          next_state = hsid_pkg::COMPARE_MSE;
        end
      end
      hsid_pkg::COMPARE_MSE: begin
        if (msi_comparison_valid) begin
          next_state = hsid_pkg::DONE;
        end
      end
      hsid_pkg::DONE: begin
        done       = 1'b1;  // Single-cycle pulse
        next_state = hsid_pkg::IDLE;
      end
      default: begin
        idle       = 1'b1;
        next_state = hsid_pkg::IDLE;
      end
    endcase
  end

endmodule

// File: hw/hsid_min_search.sv
`timescale 1ns/1ps

module hsid_min_search (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  msi_valid,        // New candidate
  input  logic                  msi_final,        // Candidate is the last of the run
  input  hsid_pkg::mse_t        msi_mse,
  input  hsid_pkg::lib_index_t  msi_index,
  output hsid_pkg::mse_t        best_mse,         // Smallest MSE so far
  output hsid_pkg::lib_index_t  best_index,       // Its library entry
  output logic                  comparison_valid  // Run result settled
);

  logic take;  // Candidate becomes the best entry

  // Index 0 opens a run, otherwise strictly smaller wins
  // so equal MSEs keep the lower index
  assign take = msi_valid &&
                ((msi_index == '0) || (msi_mse < best_mse));

  // Completion pulse after the last candidate
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      comparison_valid <= 1'b0;
    end else begin
      comparison_valid <= msi_valid && msi_final;
    end
  end

  // Best entry registers
  always_ff @(posedge clk) begin
    if (take) begin
      best_mse   <= msi_mse;
      best_index <= msi_index;
    end
  end

endmodule

// File: hw/hsid_mse.sv
`timescale 1ns/1ps

module hsid_mse (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  element_valid,  // Word pair present
  input  logic                  element_start,  // First pair of a vector
  input  logic                  element_last,   // Last pair of a vector
  input  logic                  vctr_last,      // Vector is the last in the run
  input  hsid_pkg::lib_index_t  vctr_count,     // Index of the current vector
  input  hsid_pkg::element_t    meas_element,   // Pixel word
  input  hsid_pkg::element_t    ref_element,    // Library word
  output logic                  msi_valid,      // One result per vector
  output logic                  msi_final,      // Result of the last vector
  output hsid_pkg::mse_t        msi_mse,
  output hsid_pkg::lib_index_t  msi_index
);

  hsid_pkg::band_t  diff_lo;   // |meas - ref|, low band
  hsid_pkg::band_t  diff_hi;   // |meas - ref|, high band
  hsid_pkg::sq_t    sq_lo;
  hsid_pkg::sq_t    sq_hi;
  hsid_pkg::sum_t   acc;       // Running sum over the vector
  hsid_pkg::sum_t   acc_base;  // Zero on the first word
  hsid_pkg::sum_t   sum_next;  // Sum including this word
  logic             vec_done;  // Closing word of a vector

  // Magnitude of an unsigned difference
  function automatic hsid_pkg::band_t abs_diff(input hsid_pkg::band_t a,
                                               input hsid_pkg::band_t b);
    hsid_pkg::band_t d;
    if (a >= b) begin
      d = a - b;
    end else begin
      d = b - a;
    end
    return d;
  endfunction

  always_comb begin
    diff_lo  = abs_diff(meas_element[0], ref_element[0]);
    diff_hi  = abs_diff(meas_element[1], ref_element[1]);
    sq_lo    = hsid_pkg::sq_t'(diff_lo) * hsid_pkg::sq_t'(diff_lo);  // Full 32-bit product
    sq_hi    = hsid_pkg::sq_t'(diff_hi) * hsid_pkg::sq_t'(diff_hi);
    acc_base = element_start ? '0 : acc;  // Restart per vector
    sum_next = acc_base + hsid_pkg::sum_t'(sq_lo) + hsid_pkg::sum_t'(sq_hi);
  end

  assign vec_done = element_valid && element_last;

  // Result strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      msi_valid <= 1'b0;
      msi_final <= 1'b0;
    end else begin
      msi_valid <= vec_done;
      msi_final <= vec_done && vctr_last;  // Only with the last result
    end
  end

  // Accumulator and result payload
  always_ff @(posedge clk) begin
    if (element_valid) begin
      acc <= sum_next;
    end
    if (vec_done) begin
      msi_mse   <= hsid_pkg::mse_t'(sum_next >> hsid_pkg::MSE_SHIFT);  // Divide by band count
      msi_index <= vctr_count;
    end
  end

endmodule

// File: hw/hsid_pkg.sv
package hsid_pkg;

  // Pixel geometry
  localparam int HSI_BANDS     = 8;                 // Bands per pixel
  localparam int ELEMENTS      = HSI_BANDS / 2;     // Two bands per word
  localparam int ELEMENTS_ADDR = $clog2(ELEMENTS);  // Element counter width

  // Library geometry
  localparam int HSI_LIBRARY_SIZE      = 16;                        // Max reference vectors
  localparam int HSI_LIBRARY_SIZE_ADDR = $clog2(HSI_LIBRARY_SIZE);  // Index width

  // Datapath widths
  localparam int BAND_WIDTH = 16;                      // One band sample
  localparam int SQ_WIDTH   = 2 * BAND_WIDTH;          // Square of a band difference
  localparam int MSE_SHIFT  = $clog2(HSI_BANDS);       // Divide by band count
  localparam int SUM_WIDTH  = SQ_WIDTH + MSE_SHIFT;    // Sum of all squares, no overflow
  localparam int MSE_WIDTH  = 32;                      // Scaled result

  // Buffering
  localparam int REF_FIFO_DEPTH = 4;  // Reference words in flight

  typedef logic [BAND_WIDTH-1:0] band_t;  // Unsigned sample

  // Index 0 is the low band
  typedef logic [1:0][BAND_WIDTH-1:0] element_t;

  typedef logic [HSI_LIBRARY_SIZE_ADDR-1:0] lib_index_t;  // Vector index
  typedef logic [HSI_LIBRARY_SIZE_ADDR:0]   lib_size_t;   // Holds full size too

  typedef logic [SQ_WIDTH-1:0]  sq_t;   // Squared difference
  typedef logic [SUM_WIDTH-1:0] sum_t;  // Running sum
  typedef logic [MSE_WIDTH-1:0] mse_t;  // Sum >> MSE_SHIFT

  // Run controller states
  typedef enum logic [2:0] {
    IDLE,          // Waiting for start
    READ_MEASURE,  // Loading the pixel
    COMPUTE_MSE,   // Streaming library vectors
    WAIT_MSE,      // Last MSE in flight
    COMPARE_MSE,   // Last comparison in flight
    DONE           // One-cycle completion
  } hsid_main_state_t;

endpackage

// File: hw/hsid_top.sv
`timescale 1ns/1ps

module hsid_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,             // Begin a run
  input  hsid_pkg::lib_size_t   hsi_library_size,  // Stable during a run
  input  hsid_pkg::element_t    meas_data,         // Pixel word from host
  input  logic                  meas_valid,
  input  hsid_pkg::element_t    ref_data,          // Library word from host
  input  logic                  ref_valid,
  output logic                  idle,
  output logic                  ready,             // Host back-pressure
  output logic                  done,              // End of run pulse
  output hsid_pkg::lib_index_t  best_index,
  output hsid_pkg::mse_t        best_mse
);

  hsid_pkg::hsid_main_state_t  state;
  hsid_pkg::lib_index_t        vctr_count;
  logic                        element_start;
  logic                        element_last;
  logic                        element_valid;
  logic                        vctr_last;
  logic                        fifo_both_read_en;    // Joint pop of both buffers
  logic                        fifo_measure_full;
  logic                        fifo_measure_empty;
  logic                        fifo_ref_full;
  logic                        fifo_ref_empty;
  hsid_pkg::element_t          meas_rd_data;          // Pixel word to the accumulator
  hsid_pkg::element_t          ref_rd_data;           // Library word to the accumulator
  hsid_pkg::element_t          meas_wr_data;
  logic                        meas_wr_en;
  logic                        host_meas_wr;          // Host load
  logic                        recirc_wr;             // Write-back of a used pixel word
  logic                        ref_wr_en;
  logic                        msi_valid;
  logic                        msi_final;
  hsid_pkg::mse_t              msi_mse;
  hsid_pkg::lib_index_t        msi_index;
  logic                        comparison_valid;

  assign host_meas_wr = (state == hsid_pkg::READ_MEASURE) && meas_valid && !fifo_measure_full;
  // Last vector drains the pixel so the next run starts empty
  assign recirc_wr    = element_valid && !vctr_last;
  assign meas_wr_en   = host_meas_wr || recirc_wr;
  assign meas_wr_data = recirc_wr ? meas_rd_data : meas_data;  // Recirculate or load

  assign ref_wr_en = ref_valid && ready && !fifo_ref_full;

  hsid_fifo #(.payload_t(hsid_pkg::element_t), .DEPTH(hsid_pkg::ELEMENTS)) measure_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (meas_wr_en),
    .wr_data (meas_wr_data),
    .rd_en   (fifo_both_read_en),
    .rd_data (meas_rd_data),
    .full    (fifo_measure_full),
    .empty   (fifo_measure_empty)
  );

  hsid_fifo #(.payload_t(hsid_pkg::element_t), .DEPTH(hsid_pkg::REF_FIFO_DEPTH)) ref_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (ref_wr_en),
    .wr_data (ref_data),
    .rd_en   (fifo_both_read_en),
    .rd_data (ref_rd_data),
    .full    (fifo_ref_full),
    .empty   (fifo_ref_empty)
  );

  hsid_main_fsm main_fsm_i (
    .clk                  (clk),
    .rst_n                (rst_n),
    .hsi_library_size     (hsi_library_size),
    .fifo_measure_full    (fifo_measure_full),
    .fifo_measure_empty   (fifo_measure_empty),
    .fifo_ref_empty       (fifo_ref_empty),
    .fifo_ref_full        (fifo_ref_full),
    .msi_valid            (msi_final),         // Only the last result ends WAIT_MSE
    .msi_comparison_valid (comparison_valid),
    .start                (start),
    .state                (state),
    .vctr_count           (vctr_count),
    .element_start        (element_start),
    .element_last         (element_last),
    .element_valid        (element_valid),
    .vctr_last            (vctr_last),
    .fifo_both_read_en    (fifo_both_read_en),
    .done                 (done),
    .idle                 (idle),
    .ready                (ready)
  );

  hsid_mse mse_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .element_valid (element_valid),
    .element_start (element_start),
    .element_last  (element_last),
    .vctr_last     (vctr_last),
    .vctr_count    (vctr_count),
    .meas_element  (meas_rd_data),
    .ref_element   (ref_rd_data),
    .msi_valid     (msi_valid),
    .msi_final     (msi_final),
    .msi_mse       (msi_mse),
    .msi_index     (msi_index)
  );

  hsid_min_search min_search_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .msi_valid        (msi_valid),
    .msi_final        (msi_final),
    .msi_mse          (msi_mse),
    .msi_index        (msi_index),
    .best_mse         (best_mse),
    .best_index       (best_index),
    .comparison_valid (comparison_valid)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the hsid testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f build.f --top-module hsid_tb -Mdir obj_dir -o hsid_sim

out=$(./obj_dir/hsid_sim)
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// File: verification/hsid_clk_gen.sv
`timescale 1ns/1ps

module hsid_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 50;  // 100 ns clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;  // Asserted from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Released on a falling edge like all stimulus
  end

endmodule

// File: verification/hsid_tb.sv
`timescale 1ns/1ps

module hsid_tb;

  localparam int KIND_RANDOM    = 0;  // All entries random
  localparam int KIND_EXACT     = 1;  // Entry idx is the pixel itself
  localparam int KIND_DUP       = 2;  // Near copy at idx, repeated every third entry
  localparam int NUM_CASES      = 11;
  localparam int RESET_TIMEOUT  = 40;
  localparam int READY_TIMEOUT  = 20;
  localparam int STALL_TIMEOUT  = 50;   // Cycles of ready low while streaming
  localparam int DONE_TIMEOUT   = 100;

  typedef struct packed {
    int lib_size;  // Vectors in the run
    int kind;
    int idx;       // Target entry for exact and duplicate patterns
    int gap_pct;   // Chance of an idle cycle on ref_valid
  } case_t;

  // Exact matches precede random runs so a stale best of 0 would show
  case_t cases [NUM_CASES] = '{
    '{4,  KIND_EXACT,  2,  0},
    '{1,  KIND_RANDOM, 0,  0},
    '{5,  KIND_RANDOM, 0,  0},
    '{16, KIND_RANDOM, 0,  0},
    '{16, KIND_EXACT,  15, 30},
    '{8,  KIND_DUP,    3,  0},
    '{16, KIND_DUP,    0,  50},
    '{5,  KIND_RANDOM, 0,  40},
    '{16, KIND_EXACT,  0,  0},
    '{12, KIND_RANDOM, 0,  60},
    '{1,  KIND_EXACT,  0,  25}
  };

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  hsid_pkg::lib_size_t   hsi_library_size;
  hsid_pkg::element_t    meas_data;
  logic                  meas_valid;
  hsid_pkg::element_t    ref_data;
  logic                  ref_valid;
  logic                  idle;
  logic                  ready;
  logic                  done;
  hsid_pkg::lib_index_t  best_index;
  hsid_pkg::mse_t        best_mse;

  hsid_pkg::band_t       pixel [hsid_pkg::HSI_BANDS];
  hsid_pkg::band_t       lib [hsid_pkg::HSI_LIBRARY_SIZE][hsid_pkg::HSI_BANDS];
  hsid_pkg::lib_index_t  exp_index;  // Model result of the current case
  hsid_pkg::mse_t        exp_mse;
  int                    errors;
  int                    timeouts;
  int                    runs_done;
  int                    done_count;  // done pulses seen since reset
  logic                  aborted;     // Set by a timeout

  hsid_clk_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  hsid_top hsid_top_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .start            (start),
    .hsi_library_size (hsi_library_size),
    .meas_data        (meas_data),
    .meas_valid       (meas_valid),
    .ref_data         (ref_data),
    .ref_valid        (ref_valid),
    .idle             (idle),
    .ready            (ready),
    .done             (done),
    .best_index       (best_index),
    .best_mse         (best_mse)
  );

  // Counted on the rising edge, read by the main flow on falling edges
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_count <= 0;
    end else if (done) begin
      done_count <= done_count + 1;
    end
  end

  task automatic check_mse(input hsid_pkg::mse_t actual, input hsid_pkg::mse_t expected,
                           input string what);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_index(input hsid_pkg::lib_index_t actual,
                             input hsid_pkg::lib_index_t expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_count(input int actual, input int expected, input string what);
    if (actual != expected) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what, input int limit);
    timeouts++;
    aborted = 1'b1;  // Later cases would only cascade
    $display("timeout: %s did not happen within %0d cycles, at %0t", what, limit, $time);
  endtask

  function automatic hsid_pkg::band_t rand_band();
    return hsid_pkg::band_t'($urandom_range(32'hffff));
  endfunction

  // Low band in slot 0
  function automatic hsid_pkg::element_t pack_word(input hsid_pkg::band_t lo,
                                                   input hsid_pkg::band_t hi);
    hsid_pkg::element_t w;
    w[0] = lo;
    w[1] = hi;
    return w;
  endfunction

  // Mean of squared band differences, truncated
  function automatic hsid_pkg::mse_t model_mse(input int v);
    longint sum;
    longint d;
    sum = 0;
    for (int b = 0; b < hsid_pkg::HSI_BANDS; b++) begin
      d   = longint'(pixel[b]) - longint'(lib[v][b]);
      sum = sum + d * d;
    end
    return hsid_pkg::mse_t'(sum / hsid_pkg::HSI_BANDS);
  endfunction

  task automatic build_case(input case_t tc);
    int b;
    int v;
    for (b = 0; b < hsid_pkg::HSI_BANDS; b++) begin
      pixel[b] = rand_band();
    end
    for (v = 0; v < tc.lib_size; v++) begin
      for (b = 0; b < hsid_pkg::HSI_BANDS; b++) begin
        lib[v][b] = rand_band();
      end
    end
    if (tc.kind == KIND_EXACT) begin
      for (b = 0; b < hsid_pkg::HSI_BANDS; b++) begin
        lib[tc.idx][b] = pixel[b];
      end
    end else if (tc.kind == KIND_DUP) begin
      for (b = 0; b < hsid_pkg::HSI_BANDS; b++) begin
        lib[tc.idx][b] = pixel[b] ^ hsid_pkg::band_t'($urandom_range(3));  // Tiny error
      end
      for (v = tc.idx + 3; v < tc.lib_size; v += 3) begin
        for (b = 0; b < hsid_pkg::HSI_BANDS; b++) begin
          lib[v][b] = lib[tc.idx][b];  // Identical later copies
        end
      end
    end
  endtask

  // Strictly smaller replaces, so the lowest index keeps a tie
  task automatic compute_expected(input int n);
    hsid_pkg::mse_t m;
    exp_index = '0;
    exp_mse   = model_mse(0);
    for (int v = 1; v < n; v++) begin
      m = model_mse(v);
      if (m < exp_mse) begin
        exp_mse   = m;
        exp_index = hsid_pkg::lib_index_t'(v);
      end
    end
  endtask

  task automatic wait_ready(input string what);
    int cnt;
    cnt = 0;
    while (ready !== 1'b1 && cnt < READY_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (ready !== 1'b1) begin
      report_timeout(what, READY_TIMEOUT);
    end
  endtask

  task automatic start_run(input int n);
    check_flag(idle, 1'b1, "idle before start");
    check_flag(ready, 1'b0, "ready before start");
    check_flag(done, 1'b0, "done before start");
    hsi_library_size = hsid_pkg::lib_size_t'(n);
    start            = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_flag(ready, 1'b1, "ready one cycle after start");  // Fixed latency
    check_flag(idle, 1'b0, "idle during run");
  endtask

  task automatic load_pixel();
    int e;
    for (e = 0; e < hsid_pkg::ELEMENTS; e++) begin
      wait_ready("ready for a pixel word");
      if (aborted) begin
        return;
      end
      meas_valid = 1'b1;
      meas_data  = pack_word(pixel[2 * e], pixel[2 * e + 1]);
      @(negedge clk);
    end
    meas_valid = 1'b0;
    meas_data  = '0;
  endtask

  task automatic stream_library(input int n, input int gap_pct);
    int   sent;
    int   stall;
    int   v;
    int   e;
    int   pending;   // Accepted reference words not yet popped
    logic draining;  // Pops start one edge after the pixel is complete
    sent     = 0;
    stall    = 0;
    pending  = 0;
    draining = 1'b0;
    while (sent < n * hsid_pkg::ELEMENTS) begin
      check_flag(ready, pending < hsid_pkg::REF_FIFO_DEPTH,
                 "ready against unread reference words");
      if (draining && pending > 0) begin
        pending--;  // Joint pop at the coming edge
      end
      if (ready === 1'b1 && int'($urandom_range(99)) >= gap_pct) begin
        v         = sent / hsid_pkg::ELEMENTS;
        e         = sent % hsid_pkg::ELEMENTS;
        ref_valid = 1'b1;  // Taken on the next rising edge
        ref_data  = pack_word(lib[v][2 * e], lib[v][2 * e + 1]);
        pending++;
        sent++;
      end else begin
        ref_valid = 1'b0;  // Host gap or back-pressure
      end
      draining = 1'b1;
      stall = (ready === 1'b1) ? 0 : stall + 1;
      if (stall > STALL_TIMEOUT) begin
        ref_valid = 1'b0;
        report_timeout("ready for a reference word", STALL_TIMEOUT);
        return;
      end
      @(negedge clk);
    end
    ref_valid = 1'b0;
    ref_data  = '0;
  endtask

  task automatic wait_done();
    int cnt;
    cnt = 0;
    while (done !== 1'b1 && cnt < DONE_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (done !== 1'b1) begin
      report_timeout("done", DONE_TIMEOUT);
    end
  endtask

  task automatic run_case(input int c);
    case_t tc;
    tc = cases[c];
    build_case(tc);
    compute_expected(tc.lib_size);
    $display("case %0d: %0d vectors, kind %0d, gaps %0d%%, expect entry %0d mse %0d",
             c, tc.lib_size, tc.kind, tc.gap_pct, exp_index, exp_mse);
    start_run(tc.lib_size);
    load_pixel();
    if (aborted) begin
      return;
    end
    stream_library(tc.lib_size, tc.gap_pct);
    if (aborted) begin
      return;
    end
    wait_done();
    if (aborted) begin
      return;
    end
    check_index(best_index, exp_index, "best_index");
    check_mse(best_mse, exp_mse, "best_mse");
    @(negedge clk);
    runs_done++;
    check_flag(done, 1'b0, "done after its pulse");
    check_flag(idle, 1'b1, "idle after done");
    check_count(done_count, runs_done, "done pulses so far");  // Exactly one per run
  endtask

  initial begin
    int cnt;
    int c;
    start            = 1'b0;
    hsi_library_size = '0;
    meas_data        = '0;
    meas_valid       = 1'b0;
    ref_data         = '0;
    ref_valid        = 1'b0;
    errors           = 0;
    timeouts         = 0;
    runs_done        = 0;
    aborted          = 1'b0;
    void'($urandom(32'hf736));  // Single seeding for the whole run
    cnt              = 0;
    while (rst_n !== 1'b1 && cnt < RESET_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (rst_n !== 1'b1) begin
      report_timeout("reset release", RESET_TIMEOUT);
    end else begin
      @(negedge clk);
      check_flag(idle, 1'b1, "idle after reset");
      check_flag(ready, 1'b0, "ready after reset");
      check_flag(done, 1'b0, "done after reset");
    end
    for (c = 0; c < NUM_CASES; c++) begin
      if (!aborted) begin
        run_case(c);
      end
    end
    $display("%0d runs, %0d errors, %0d timeouts", runs_done, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
